//--- rtl/multicore_defines.svh
`ifndef MULTICORE_DEFINES_SVH
`define MULTICORE_DEFINES_SVH

// Number of summing cores in the array.
`define MC_CORES 4

// Samples per block, one block per core in rotation.
`define MC_BLOCK_LEN 4

`define MC_RELEASE_GAP 12 // Cycles between core releases.

`define MC_SAMPLE_W 31 // Signed sample and sum width.

`endif

//--- rtl/multicore_pkg.sv
`default_nettype none

`include "multicore_defines.svh"

package multicore_pkg;

	typedef logic signed [`MC_SAMPLE_W-1:0] sample_t;

	// Core number, kept at least one bit wide.
	typedef logic [$clog2(`MC_CORES > 1 ? `MC_CORES : 2)-1:0] core_idx_t;

	typedef logic [$clog2(`MC_BLOCK_LEN > 1 ? `MC_BLOCK_LEN : 2)-1:0] beat_cnt_t;

	typedef enum logic {
		CORE_ACCUM, // Summing the current block.
		CORE_HOLD   // Sum waits for the collector.
	} core_state_e;

endpackage

`default_nettype wire

//--- rtl/core_link_if.sv
`default_nettype none

interface core_link_if;
	import multicore_pkg::*;

	logic sample_valid;
	sample_t sample_data;
	logic sample_last; // Final beat of a block.
	logic sample_ready;

	logic result_valid;
	sample_t result_data;
	logic result_ready;

	modport dispatcher (
		output sample_valid,
		output sample_data,
		output sample_last,
		input sample_ready
	);

	modport core (
		input sample_valid,
		input sample_data,
		input sample_last,
		output sample_ready,
		output result_valid,
		output result_data,
		input result_ready
	);

	modport collector (
		input result_valid,
		input result_data,
		output result_ready
	);

endinterface

`default_nettype wire

//--- rtl/reset_sequencer.sv
`default_nettype none

`include "multicore_defines.svh"

module reset_sequencer (
	input logic clk,
	input logic reset,
	output logic [`MC_CORES-1:0] core_reset
);
	import multicore_pkg::*;

	localparam int GAP_W = $clog2(`MC_RELEASE_GAP + 1);

	logic [GAP_W-1:0] gap_cnt;
	core_idx_t rel_idx; // Next core to release.
	logic done;

	always_ff @(posedge clk) begin
		if (reset) begin
			core_reset <= '1;
			gap_cnt <= '0;
			rel_idx <= '0;
			done <= 1'b0;
		end else if (!done) begin
			if (gap_cnt == GAP_W'(`MC_RELEASE_GAP - 1)) begin
				gap_cnt <= '0;
				core_reset[rel_idx] <= 1'b0;
				rel_idx <= rel_idx + 1'b1;
				if (rel_idx == core_idx_t'(`MC_CORES - 1)) begin
					done <= 1'b1; // All cores running.
				end
			end else begin
				gap_cnt <= gap_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/sample_dispatcher.sv
`default_nettype none

`include "multicore_defines.svh"

module sample_dispatcher (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input multicore_pkg::sample_t wb_dat,
	output logic wb_ack,
	core_link_if.dispatcher links [`MC_CORES]
);
	import multicore_pkg::*;

	core_idx_t cur_core;
	beat_cnt_t beat;
	logic req;
	logic take;
	logic last_beat;
	logic [`MC_CORES-1:0] ready_vec;

	// Master still holds the write in the ack cycle.
	assign req = wb_cyc && wb_stb && wb_we && !wb_ack;
	assign last_beat = (beat == beat_cnt_t'(`MC_BLOCK_LEN - 1));
	assign take = req && ready_vec[cur_core];

	for (genvar k = 0; k < `MC_CORES; k++) begin : g_link
		assign links[k].sample_valid = req && (cur_core == core_idx_t'(k));
		assign links[k].sample_data = wb_dat;
		assign links[k].sample_last = last_beat;
		assign ready_vec[k] = links[k].sample_ready;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			cur_core <= '0;
			beat <= '0;
		end else begin
			wb_ack <= take;
			if (take) begin
				if (last_beat) begin
					beat <= '0;
					if (cur_core == core_idx_t'(`MC_CORES - 1)) begin
						cur_core <= '0;
					end else begin
						cur_core <= cur_core + 1'b1; // Next block, next core.
					end
				end else begin
					beat <= beat + 1'b1;
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> wb_cyc && wb_stb);

endmodule

`default_nettype wire

//--- rtl/block_core.sv
`default_nettype none

`include "multicore_defines.svh"

module block_core (
	input logic clk,
	input logic core_reset,
	core_link_if.core link
);
	import multicore_pkg::*;

	core_state_e state;
	sample_t acc;
	sample_t sum_next;
	sample_t result_q;
	logic ready_q;
	logic take;

	assign take = link.sample_valid && link.sample_ready;
	assign sum_next = acc + link.sample_data; // Wraps at the sample width.

	assign link.sample_ready = ready_q;
	assign link.result_valid = (state == CORE_HOLD);
	assign link.result_data = result_q;

	always_ff @(posedge clk) begin
		if (core_reset) begin
			state <= CORE_ACCUM;
			acc <= '0;
			ready_q <= 1'b0;
		end else begin
			case (state)
				CORE_ACCUM: begin
					ready_q <= 1'b1;
					if (take) begin
						if (link.sample_last) begin
							state <= CORE_HOLD;
							ready_q <= 1'b0;
						end else begin
							acc <= sum_next;
						end
					end
				end
				CORE_HOLD: begin
					if (link.result_ready) begin
						state <= CORE_ACCUM;
						acc <= '0; // Fresh block.
						ready_q <= 1'b1;
					end
				end
				default: begin
					state <= CORE_ACCUM;
					ready_q <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take && link.sample_last) begin
			result_q <= sum_next;
		end
	end

	assert property (@(posedge clk) disable iff (core_reset)
		state == CORE_HOLD |-> !take);

	assert property (@(posedge clk) disable iff (core_reset)
		link.result_valid && !link.result_ready |=>
			link.result_valid && $stable(link.result_data));

endmodule

`default_nettype wire

//--- rtl/result_collector.sv
`default_nettype none

`include "multicore_defines.svh"

module result_collector (
	input logic clk,
	input logic reset,
	core_link_if.collector links [`MC_CORES],
	output logic out_valid,
	output multicore_pkg::sample_t out_data,
	output multicore_pkg::core_idx_t out_core,
	input logic out_ready
);
	import multicore_pkg::*;

	core_idx_t next_core; // Owner of the next block in order.
	logic can_load;
	logic take;
	logic [`MC_CORES-1:0] valid_vec;
	sample_t data_vec [`MC_CORES];

	assign can_load = !out_valid || out_ready; // Register empty or draining.
	assign take = can_load && valid_vec[next_core];

	for (genvar k = 0; k < `MC_CORES; k++) begin : g_link
		assign links[k].result_ready = can_load && (next_core == core_idx_t'(k));
		assign valid_vec[k] = links[k].result_valid;
		assign data_vec[k] = links[k].result_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			next_core <= '0;
		end else if (take) begin
			out_valid <= 1'b1;
			if (next_core == core_idx_t'(`MC_CORES - 1)) begin
				next_core <= '0;
			end else begin
				next_core <= next_core + 1'b1;
			end
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_data <= data_vec[next_core];
			out_core <= next_core;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=>
			out_valid && $stable(out_data) && $stable(out_core));

endmodule

`default_nettype wire

//--- rtl/multicore.sv
`default_nettype none

`include "multicore_defines.svh"

module multicore (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input multicore_pkg::sample_t wb_dat,
	output logic wb_ack,
	output logic out_valid,
	output multicore_pkg::sample_t out_data,
	output multicore_pkg::core_idx_t out_core,
	input logic out_ready
);

	logic [`MC_CORES-1:0] core_reset; // One staggered reset per core.

	core_link_if links [`MC_CORES] ();

	reset_sequencer u_reset_sequencer (
		.clk(clk),
		.reset(reset),
		.core_reset(core_reset)
	);

	sample_dispatcher u_sample_dispatcher (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack),
		.links(links)
	);

	for (genvar k = 0; k < `MC_CORES; k++) begin : g_core
		block_core u_block_core (
			.clk(clk),
			.core_reset(core_reset[k]),
			.link(links[k])
		);
	end

	result_collector u_result_collector (
		.clk(clk),
		.reset(reset),
		.links(links),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_core(out_core),
		.out_ready(out_ready)
	);

endmodule

`default_nettype wire

//--- sim/multicore_tb.sv
`default_nettype none

`include "multicore_defines.svh"

module multicore_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import multicore_pkg::*;

	localparam int NUM_BLOCKS = 38;
	localparam int STIM_COLS = `MC_BLOCK_LEN + 1; // Samples, then the sum.
	localparam int RESET_CYCLES = 8;
	localparam int READ_WINDOW = 10;
	localparam int TIMEOUT_CYCLES = NUM_BLOCKS * (`MC_BLOCK_LEN + 20) * 4
		+ `MC_CORES * `MC_RELEASE_GAP + RESET_CYCLES + 2 * READ_WINDOW;
	localparam int NUM_TESTS = 6;
	localparam int T_RELEASE = 0;
	localparam int T_SUM = 1;
	localparam int T_ORDER = 2;
	localparam int T_LATENCY = 3;
	localparam int T_STALL = 4;
	localparam int T_READ = 5;

	logic clk = 1'b0;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	sample_t wb_dat;
	logic wb_ack;
	logic out_valid;
	sample_t out_data;
	core_idx_t out_core;
	logic out_ready;

	logic [`MC_SAMPLE_W-1:0] stim_mem [NUM_BLOCKS * STIM_COLS];
	int checks [NUM_TESTS];
	int errors [NUM_TESTS];
	logic [31:0] gap_state;
	logic [31:0] stall_state;
	int stall_left;
	int run_cycles;
	int live_cycles; // Cycles since reset dropped.
	int ack_count;
	int result_count;
	logic hold_seen;
	logic [`MC_SAMPLE_W-1:0] hold_data;
	core_idx_t hold_core;
	logic latency_due;
	core_idx_t latency_core;

	multicore u_multicore (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_core(out_core),
		.out_ready(out_ready)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic string test_name(input int idx);
		case (idx)
			T_RELEASE: return "staggered_release";
			T_SUM: return "block_sums";
			T_ORDER: return "order_and_core";
			T_LATENCY: return "latency";
			T_STALL: return "backpressure";
			default: return "ignored_reads";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected, input int test_id);
		checks[test_id]++;
		if (got !== expected) begin
			errors[test_id]++;
			$display("Error: %s is 0x%0h, expected 0x%0h (test %s, cycle %0d)",
				name, got, expected, test_name(test_id), live_cycles);
		end
	endtask

	task automatic report_failure(input int test_id, input string what);
		errors[test_id]++;
		$display("Failure in test %s at cycle %0d: %s", test_name(test_id), live_cycles, what);
	endtask

	task automatic print_test_line(input int idx);
		$display("Test %s: %0d checks, %0d errors", test_name(idx), checks[idx], errors[idx]);
	endtask

	// Wishbone classic write, held through the ack cycle.
	task automatic write_sample(input logic [`MC_SAMPLE_W-1:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_dat = data;
		@(negedge clk);
		while (!wb_ack) @(negedge clk);
		@(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic issue_read(input logic [`MC_SAMPLE_W-1:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_dat = data;
		repeat (READ_WINDOW) begin
			@(negedge clk);
			check_value("wb_ack", wb_ack, 0, T_READ);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// Random out_ready, with occasional long stall bursts.
	initial begin
		forever begin
			@(negedge clk);
			if (stall_left > 0) begin
				out_ready = 1'b0;
				stall_left--;
			end else begin
				stall_state = xorshift32(stall_state);
				if (stall_state[3:0] == 4'd0) begin
					stall_left = int'(stall_state[7:4]);
					out_ready = 1'b0;
				end else begin
					out_ready = (stall_state[9:8] != 2'd0);
				end
			end
		end
	end

	always @(posedge clk) begin
		int blk;
		int beat;
		run_cycles++;
		if (run_cycles > TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with %0d of %0d results received",
				run_cycles, result_count, NUM_BLOCKS);
			$display("TESTS FAILED");
			$finish;
		end else if (!reset) begin
			live_cycles++;
			if (latency_due) begin
				check_value("out_valid", out_valid, 1, T_LATENCY);
				check_value("out_core", out_core, latency_core, T_LATENCY);
				latency_due = 1'b0;
			end
			if (hold_seen) begin
				check_value("out_valid", out_valid, 1, T_STALL);
				check_value("out_data", $unsigned(out_data), hold_data, T_STALL);
				check_value("out_core", out_core, hold_core, T_STALL);
			end
			hold_seen = out_valid && !out_ready;
			hold_data = out_data;
			hold_core = out_core;
			if (wb_ack) begin
				blk = ack_count / `MC_BLOCK_LEN;
				beat = ack_count % `MC_BLOCK_LEN;
				if (beat == 0) begin
					checks[T_RELEASE]++;
					if (live_cycles <= (blk % `MC_CORES + 1) * `MC_RELEASE_GAP) begin
						report_failure(T_RELEASE, $sformatf(
							"block %0d was acknowledged before core %0d left reset",
							blk, blk % `MC_CORES));
					end
				end
				// Output idle and all earlier blocks gone.
				if (beat == `MC_BLOCK_LEN - 1 && !out_valid && out_ready
						&& result_count == blk) begin
					latency_due = 1'b1;
					latency_core = core_idx_t'(blk % `MC_CORES);
				end
				ack_count++;
			end
			if (out_valid && out_ready) begin
				if (result_count >= NUM_BLOCKS) begin
					report_failure(T_STALL, "a result arrived after the last block");
				end else begin
					check_value("out_data", $unsigned(out_data),
						stim_mem[result_count * STIM_COLS + `MC_BLOCK_LEN], T_SUM);
					check_value("out_core", out_core, result_count % `MC_CORES, T_ORDER);
				end
				result_count++;
			end
		end
	end

	initial begin
		int total_checks;
		int total_errors;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_dat = '0;
		out_ready = 1'b1;
		gap_state = 32'd2022;
		stall_state = xorshift32(32'd2022);
		stall_left = 0;
		run_cycles = 0;
		live_cycles = 0;
		ack_count = 0;
		result_count = 0;
		hold_seen = 1'b0;
		latency_due = 1'b0;
		foreach (checks[i]) begin
			checks[i] = 0;
			errors[i] = 0;
		end
		$readmemh("sim/multicore_stim.txt", stim_mem);
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int blk = 0; blk < NUM_BLOCKS; blk++) begin
			for (int beat = 0; beat < `MC_BLOCK_LEN; beat++) begin
				if (blk == 2 && beat == 0) begin
					issue_read(stim_mem[blk * STIM_COLS + beat]); // Between blocks.
				end else if (blk == 5 && beat == 2) begin
					issue_read(31'h7fffffff); // Inside a block.
					print_test_line(T_READ);
				end
				gap_state = xorshift32(gap_state);
				repeat (int'(gap_state[1:0])) @(negedge clk);
				write_sample(stim_mem[blk * STIM_COLS + beat]);
			end
		end
		while (result_count < NUM_BLOCKS) @(negedge clk);
		repeat (8) @(negedge clk); // Room for a duplicate to show.
		check_value("result_count", result_count, NUM_BLOCKS, T_STALL);
		check_value("ack_count", ack_count, NUM_BLOCKS * `MC_BLOCK_LEN, T_ORDER);
		if (checks[T_LATENCY] == 0) begin
			report_failure(T_LATENCY, "no block ended while the output was idle");
		end
		for (int t = 0; t < T_READ; t++) begin
			print_test_line(t);
		end
		total_checks = 0;
		total_errors = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			total_checks += checks[t];
			total_errors += errors[t];
		end
		$display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, total_checks,
			total_errors);
		if (total_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/multicore_stim.txt
// Columns: sample 0, sample 1, sample 2, sample 3, expected sum (31-bit hex).
// Sums wrap modulo 2^31; one block per line, in block order.
00000001 00000002 00000003 00000004 0000000A
00000010 00000020 00000030 00000040 000000A0
7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFC
3FFFFFFF 00000001 00000000 00000000 40000000
40000000 40000000 00000001 00000002 00000003
00000000 00000000 00000000 00000000 00000000
12345678 01010101 00000000 00000000 13355779
7FFFFFFF 00000001 00000005 00000000 00000005
00001000 00002000 00003000 00004000 0000A000
7FFFFFF0 00000010 7FFFFFF0 00000010 00000000
20000000 20000000 20000000 20000001 00000001
00000100 00000200 00000300 00000400 00000A00
7FFFFFFE 7FFFFFFE 00000001 00000001 7FFFFFFE
55555555 2AAAAAAA 00000001 00000000 00000000
0ABCDEF0 00000001 00000002 00000003 0ABCDEF6
60000000 60000000 00000000 00000000 40000000
00000007 00000007 00000007 00000007 0000001C
7FFFFF00 00000080 00000040 00000040 00000000
00010000 00020000 00030000 00040000 000A0000
40000000 00000000 00000000 00000000 40000000
7FFFFFFF 7FFFFFFF 00000000 00000002 00000000
11111111 22222222 33333333 00000000 66666666
00000005 7FFFFFFB 00000003 00000004 00000007
3FFFFFFF 3FFFFFFF 00000003 00000000 00000001
00000ABC 00000DEF 00000000 00000000 000018AB
7FFFFFF6 7FFFFFF6 7FFFFFF6 7FFFFFF6 7FFFFFD8
01000000 02000000 03000000 04000000 0A000000
00000001 00000001 00000001 7FFFFFFF 00000002
7F000000 00800000 00000000 00000000 7F800000
0FFFFFFF 00000001 0FFFFFFF 00000001 20000000
00000003 00000005 00000009 00000011 00000022
50000000 50000000 50000000 00000000 70000000
7FFFFFFD 00000002 00000002 00000002 00000003
00000100 7FFFFF00 00000100 7FFFFF00 00000000
13579BDF 02468ACE 00000000 00000000 159E26AD
00000020 00000040 00000060 00000080 00000140
7FFFFFFF 00000000 00000000 00000000 7FFFFFFF
2AAAAAAA 2AAAAAAA 2AAAAAAA 00000001 7FFFFFFF

//--- verilog.f
+incdir+rtl
rtl/multicore_pkg.sv
rtl/core_link_if.sv
rtl/reset_sequencer.sv
rtl/sample_dispatcher.sv
rtl/block_core.sv
rtl/result_collector.sv
rtl/multicore.sv
sim/multicore_tb.sv

//--- Bender.yml
package:
  name: multicore

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/multicore_pkg.sv
      - rtl/core_link_if.sv
      - rtl/reset_sequencer.sv
      - rtl/sample_dispatcher.sv
      - rtl/block_core.sv
      - rtl/result_collector.sv
      - rtl/multicore.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/multicore_tb.sv
